// ==== bench/bootPreloadTb.sv ====
`timescale 1ns/1ps

module bootPreloadTb;

    logic clk;
    logic rstN;
    logic start;
    logic romMode;
    logic streamValid;
    memPkg::tPaddr streamAddr;
    memPkg::tWord streamData;
    logic done;
    logic fetchReq;
    memPkg::tPaddr fetchAddr;
    memPkg::tWord fetchData;
    logic fetchValid;

    // Reference store with one entry per word
    memPkg::tWord model [memPkg::STORE_LINES * memPkg::LINE_WORDS];
    // Word indices written by the latest stream load
    logic [9:0] written [$];

    integer seed;
    int errors;
    int checks;
    int doneRises;
    logic doneQ;

    bootPreload dut (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .romMode     (romMode),
        .streamValid (streamValid),
        .streamAddr  (streamAddr),
        .streamData  (streamData),
        .done        (done),
        .fetchReq    (fetchReq),
        .fetchAddr   (fetchAddr),
        .fetchData   (fetchData),
        .fetchValid  (fetchValid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Count done edges mid-cycle where done is settled
    always @(negedge clk) begin
        if (done && !doneQ) begin
            doneRises = doneRises + 1;
        end
        doneQ = done;
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic expectTrue(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            $display("FAIL %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // One idle cycle first so the previous fetchValid pulse can end
    task automatic fetchWord(input memPkg::tPaddr addr, output memPkg::tWord data);
        int waited;
        nextCycle();
        expectTrue(!fetchValid, $sformatf("fetchValid longer than one cycle before %h", addr));
        fetchReq = 1'b1;
        fetchAddr = addr;
        waited = 0;
        do begin
            nextCycle();
            fetchReq = 1'b0;
            waited++;
        end while (!fetchValid && waited < 8);
        data = fetchData;
        if (!fetchValid) begin
            $display("Timeout: fetch of address %h never returned fetchValid", addr);
            errors++;
        end else begin
            expectTrue(waited == 1, $sformatf("fetchValid %0d cycles after request", waited));
        end
    endtask

    task automatic compareFetch(input logic [9:0] idx);
        memPkg::tWord got;
        fetchWord(memPkg::tPaddr'({idx, 2'b00}), got);
        checks++;
        assert (got === model[idx]) else begin
            $display("FAIL %0t: word at %h read %h, expected %h",
                $time, {idx, 2'b00}, got, model[idx]);
            errors++;
        end
    endtask

    task automatic waitDone(input int limit);
        int waited;
        waited = 0;
        while (!done && waited < limit) begin
            nextCycle();
            waited++;
        end
        if (!done) begin
            $display("Timeout: done did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic pulseStart(input logic rom);
        start = 1'b1;
        romMode = rom;
        nextCycle();
        start = 1'b0;
    endtask

    // Random gap before one strobe
    // Sentinel pairs leave the model alone
    task automatic sendPair(input memPkg::tPaddr addr, input memPkg::tWord data);
        int gap;
        gap = {$random(seed)} % 4;
        repeat (gap) nextCycle();
        streamValid = 1'b1;
        streamAddr = addr;
        streamData = data;
        nextCycle();
        streamValid = 1'b0;
        if (!addr[0]) begin
            model[addr[11:2]] = data;
            written.push_back(addr[11:2]);
        end
    endtask

    // strayAt is the pair index before which a stray start goes out
    task automatic randomStream(input int count, input int strayAt);
        logic [9:0] idx;
        written.delete();
        pulseStart(1'b0);
        for (int n = 0; n < count; n++) begin
            // About one in four reuses an address already sent
            if (written.size() > 0 && ($random(seed) & 3) == 0) begin
                idx = written[{$random(seed)} % written.size()];
            end else begin
                idx = 10'($random(seed));
            end
            if (n == strayAt) begin
                pulseStart(1'b1);
            end
            sendPair(memPkg::tPaddr'({idx, 2'b00}), $random(seed));
        end
        sendPair(12'h001, 32'h0);
        waitDone(40);
    endtask

    task automatic checkStream(input int samples);
        for (int i = 0; i < written.size(); i++) begin
            compareFetch(written[i]);
        end
        for (int i = 0; i < samples; i++) begin
            compareFetch(10'($random(seed)));
        end
    endtask

    // Few words into lines that already hold data
    // Every word of those lines is read back
    task automatic overlayLines(input int lineCount);
        logic [5:0] lines [$];
        logic [3:0] slot;
        lines.push_back(6'd0);
        for (int l = 1; l < lineCount; l++) begin
            lines.push_back(written[{$random(seed)} % written.size()][9:4]);
        end
        written.delete();
        pulseStart(1'b0);
        foreach (lines[l]) begin
            for (int k = 0; k < 3; k++) begin
                slot = 4'($random(seed));
                sendPair(memPkg::tPaddr'({lines[l], slot, 2'b00}), $random(seed));
            end
        end
        sendPair(12'h001, 32'h0);
        waitDone(40);
        foreach (lines[l]) begin
            for (int w = 0; w < memPkg::LINE_WORDS; w++) begin
                compareFetch({lines[l], 4'(w)});
            end
        end
    endtask

    initial begin
        int risesBefore;
        memPkg::tWord got;
        seed = 32'h7b3c_b3c1;
        errors = 0;
        checks = 0;
        doneRises = 0;
        doneQ = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        romMode = 1'b0;
        streamValid = 1'b0;
        streamAddr = '0;
        streamData = '0;
        fetchReq = 1'b0;
        fetchAddr = '0;
        for (int i = 0; i < memPkg::STORE_LINES * memPkg::LINE_WORDS; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Store reads zero while idle after reset
        expectTrue(!done, "done high before any start");
        for (int i = 0; i < 20; i++) begin
            compareFetch(10'($random(seed)));
        end
        // Store clears one line per cycle after reset
        repeat (memPkg::STORE_LINES) nextCycle();

        // ROM load
        pulseStart(1'b1);
        for (int i = 0; i < instrPkg::IROM_WORDS; i++) begin
            model[i] = instrPkg::bootImage(i);
        end
        waitDone(instrPkg::IROM_WORDS + 16);
        for (int i = 0; i < instrPkg::IROM_WORDS; i++) begin
            compareFetch(10'(i));
        end
        expectTrue(doneRises == 1, $sformatf("done rose %0d times on ROM load", doneRises));
        // Hand-encoded ADDI x1, EBREAK and filler
        fetchWord(12'h000, got);
        expectTrue(got === 32'h0bb00093, $sformatf("ROM word 0 is %h", got));
        fetchWord(12'h01c, got);
        expectTrue(got === 32'h00100073, $sformatf("ROM word 7 is %h", got));
        fetchWord(12'h190, got);
        expectTrue(got === 32'h66600f13, $sformatf("ROM word 100 is %h", got));
        for (int i = 0; i < 20; i++) begin
            compareFetch(10'(instrPkg::IROM_WORDS + {$random(seed)} % 896));
        end

        // Stream load over the ROM image
        randomStream(200, -1);
        checkStream(300);

        // Partial rewrite of written lines
        overlayLines(4);

        // Stray start in the middle of a load
        risesBefore = doneRises;
        randomStream(60, 30);
        repeat (10) nextCycle();
        expectTrue(done, "done dropped after stream load with stray start");
        expectTrue(doneRises == risesBefore + 1,
            $sformatf("done rose %0d times on one load", doneRises - risesBefore));
        checkStream(50);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
logic/memPkg.sv
logic/instrPkg.sv
logic/bootRom.sv
logic/preloadSequencer.sv
logic/lineAssembler.sv
logic/l2LineStore.sv
logic/bootPreload.sv
bench/bootPreloadTb.sv

// ==== logic/bootPreload.sv ====
`timescale 1ns/1ps

module bootPreload (
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  logic          romMode,
    input  logic          streamValid,
    input  memPkg::tPaddr streamAddr,
    input  memPkg::tWord  streamData,
    output logic          done,
    input  logic          fetchReq,
    input  memPkg::tPaddr fetchAddr,
    output memPkg::tWord  fetchData,
    output logic          fetchValid
);

    // Sequencer and ROM
    logic [6:0] romAddr;
    memPkg::tWord romData;

    // Word writes into the assembler
    logic wrValid;
    memPkg::tPaddr wrAddr;
    memPkg::tWord wrData;
    logic flush;

    // Line writes into the store
    logic lineWrValid;
    memPkg::tLineIdx lineWrIdx;
    memPkg::tLine lineWrData;
    memPkg::tWordMask lineWrMask;

    preloadSequencer sequencer (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .romMode     (romMode),
        .streamValid (streamValid),
        .streamAddr  (streamAddr),
        .streamData  (streamData),
        .romData     (romData),
        .romAddr     (romAddr),
        .wrValid     (wrValid),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .flush       (flush),
        .done        (done)
    );

    bootRom rom (
        .clk     (clk),
        .romAddr (romAddr),
        .romData (romData)
    );

    lineAssembler assembler (
        .clk         (clk),
        .rstN        (rstN),
        .wrValid     (wrValid),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .flush       (flush),
        .lineWrValid (lineWrValid),
        .lineWrIdx   (lineWrIdx),
        .lineWrData  (lineWrData),
        .lineWrMask  (lineWrMask)
    );

    l2LineStore store (
        .clk         (clk),
        .rstN        (rstN),
        .lineWrValid (lineWrValid),
        .lineWrIdx   (lineWrIdx),
        .lineWrData  (lineWrData),
        .lineWrMask  (lineWrMask),
        .fetchReq    (fetchReq),
        .fetchAddr   (fetchAddr),
        .fetchData   (fetchData),
        .fetchValid  (fetchValid)
    );

endmodule

// ==== logic/bootRom.sv ====
`timescale 1ns/1ps

module bootRom (
    input  logic         clk,
    input  logic [6:0]   romAddr,
    output memPkg::tWord romData
);

    // One instruction per ROM entry
    memPkg::tWord rom [instrPkg::IROM_WORDS];

    // Contents come from the image function at elaboration
    initial begin
        for (int i = 0; i < instrPkg::IROM_WORDS; i++) begin
            rom[i] = instrPkg::bootImage(i);
        end
    end

    // Registered read
    // data for romAddr shows up the next cycle
    always_ff @(posedge clk) begin
        romData <= rom[romAddr];
    end

endmodule

// ==== logic/instrPkg.sv ====
package instrPkg;

    typedef logic [4:0] tRegIdx;
    typedef logic [11:0] tImm12;
    typedef logic [6:0] tOpcode;
    typedef logic [2:0] tFunct3;
    // Branch offset in bytes, bit 0 is dropped in the encoding
    typedef logic [12:0] tBrOff;

    // Major opcodes
    localparam tOpcode OP_IMM = 7'b0010011;
    localparam tOpcode OP_REG = 7'b0110011;
    localparam tOpcode OP_BRANCH = 7'b1100011;
    localparam tOpcode OP_SYSTEM = 7'b1110011;

    // funct3 codes that the image needs
    localparam tFunct3 F3_ADD = 3'b000;
    localparam tFunct3 F3_XOR = 3'b100;
    localparam tFunct3 F3_BNE = 3'b001;

    // Boot ROM depth in words
    localparam int IROM_WORDS = 128;

    // I-type
    function automatic memPkg::tWord rvAddi(tRegIdx rd, tRegIdx rs1, tImm12 imm);
        return {imm, rs1, F3_ADD, rd, OP_IMM};
    endfunction

    // R-type, funct7 all zero for both
    function automatic memPkg::tWord rvAdd(tRegIdx rd, tRegIdx rs1, tRegIdx rs2);
        return {7'b0000000, rs2, rs1, F3_ADD, rd, OP_REG};
    endfunction

    function automatic memPkg::tWord rvXor(tRegIdx rd, tRegIdx rs1, tRegIdx rs2);
        return {7'b0000000, rs2, rs1, F3_XOR, rd, OP_REG};
    endfunction

    // B-type, offset bits scattered over the word
    function automatic memPkg::tWord rvBne(tRegIdx rs1, tRegIdx rs2, tBrOff off);
        return {off[12], off[10:5], rs2, rs1, F3_BNE, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic memPkg::tWord rvEbreak();
        return {12'h001, 5'd0, 3'b000, 5'd0, OP_SYSTEM};
    endfunction

    // Boot program: count x4 down from 0x3f while doubling x3
    function automatic memPkg::tWord bootImage(int index);
        case (index)
            0: return rvAddi(5'd1, 5'd0, 12'h0bb);
            1: return rvAddi(5'd2, 5'd0, 12'h0f1);
            2: return rvAddi(5'd3, 5'd0, 12'h001);
            3: return rvAddi(5'd4, 5'd0, 12'h03f);
            4: return rvAdd(5'd3, 5'd3, 5'd3);
            5: return rvAddi(5'd4, 5'd4, 12'hfff);
            // Back two instructions
            6: return rvBne(5'd4, 5'd0, -13'sd8);
            7: return rvEbreak();
            // Filler marker
            default: return rvAddi(5'd30, 5'd0, 12'h666);
        endcase
    endfunction

endpackage

// ==== logic/l2LineStore.sv ====
`timescale 1ns/1ps

module l2LineStore (
    input  logic             clk,
    input  logic             rstN,
    input  logic             lineWrValid,
    input  memPkg::tLineIdx  lineWrIdx,
    input  memPkg::tLine     lineWrData,
    input  memPkg::tWordMask lineWrMask,
    input  logic             fetchReq,
    input  memPkg::tPaddr    fetchAddr,
    output memPkg::tWord     fetchData,
    output logic             fetchValid
);

    memPkg::tLine lines [memPkg::STORE_LINES];

    // Clear sweep after reset, one line per cycle
    // takes STORE_LINES cycles, loads start after it
    logic sweeping;
    memPkg::tLineIdx sweepIdx;

    memPkg::tLineIdx fetchLine;
    memPkg::tWordSel fetchSlot;
    memPkg::tWord fetchWord;
    // Line the sweep has not reached yet reads as zero
    logic fetchUnswept;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sweeping <= 1'b1;
            sweepIdx <= '0;
        end else if (sweeping) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (&sweepIdx) begin
                sweeping <= 1'b0;
            end
        end
    end

    // Array writes, per-word mask keeps the other words
    always_ff @(posedge clk) begin
        if (sweeping) begin
            lines[sweepIdx] <= '0;
        end
        if (lineWrValid) begin
            for (int w = 0; w < memPkg::LINE_WORDS; w++) begin
                if (lineWrMask[w]) begin
                    lines[lineWrIdx][w*memPkg::WORD_BITS +: memPkg::WORD_BITS] <=
                        lineWrData[w*memPkg::WORD_BITS +: memPkg::WORD_BITS];
                end
            end
        end
    end

    always_comb begin
        fetchLine = memPkg::lineOf(fetchAddr);
        fetchSlot = memPkg::slotOf(fetchAddr);
        fetchWord = lines[fetchLine][fetchSlot*memPkg::WORD_BITS +: memPkg::WORD_BITS];
        fetchUnswept = sweeping && (fetchLine >= sweepIdx);
    end

    // Fetch answers exactly one cycle later
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= fetchReq;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReq) begin
            fetchData <= fetchUnswept ? '0 : fetchWord;
        end
    end

    // Preload must not write before the sweep has finished
    noWriteDuringSweep: assert property (
        @(posedge clk) disable iff (!rstN)
        sweeping |-> !lineWrValid
    ) else $error("line write to line %0d during clear sweep", lineWrIdx);

endmodule

// ==== logic/lineAssembler.sv ====
`timescale 1ns/1ps

module lineAssembler (
    input  logic             clk,
    input  logic             rstN,
    input  logic             wrValid,
    input  memPkg::tPaddr    wrAddr,
    input  memPkg::tWord     wrData,
    input  logic             flush,
    output logic             lineWrValid,
    output memPkg::tLineIdx  lineWrIdx,
    output memPkg::tLine     lineWrData,
    output memPkg::tWordMask lineWrMask
);

    // Line under assembly
    memPkg::tLine bufData;
    memPkg::tLineIdx bufIdx;
    memPkg::tWordMask bufMask;

    memPkg::tLineIdx wrLine;
    memPkg::tWordSel wrSlot;
    memPkg::tWordMask slotBit;
    // Incoming word belongs to another line than the buffer
    logic newLine;
    // Buffer leaves for the store this cycle
    logic emit;

    always_comb begin
        wrLine = memPkg::lineOf(wrAddr);
        wrSlot = memPkg::slotOf(wrAddr);
        slotBit = memPkg::tWordMask'(1) << wrSlot;
        // Empty buffer takes any line
        newLine = (bufMask != '0) && (wrLine != bufIdx);
        emit = (wrValid && newLine) || flush;
    end

    // Mask and write strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            bufMask <= '0;
            lineWrValid <= 1'b0;
        end else begin
            // Empty buffer on a flush writes nothing
            lineWrValid <= emit && (bufMask != '0);
            if (wrValid) begin
                // Fresh mask when a new line starts
                bufMask <= (newLine ? '0 : bufMask) | slotBit;
            end else if (flush) begin
                bufMask <= '0;
            end
        end
    end

    // Line payload
    always_ff @(posedge clk) begin
        if (emit) begin
            lineWrIdx <= bufIdx;
            lineWrData <= bufData;
            lineWrMask <= bufMask;
        end
        if (wrValid) begin
            // Repeat to the same slot overwrites
            bufData[wrSlot*memPkg::WORD_BITS +: memPkg::WORD_BITS] <= wrData;
            bufIdx <= wrLine;
        end
    end

    // A word that arrives with flush would stay behind in the buffer
    wrNotWithFlush: assert property (
        @(posedge clk) disable iff (!rstN)
        !(wrValid && flush)
    ) else $error("word write to %h in the same cycle as flush", wrAddr);

endmodule

// ==== logic/memPkg.sv ====
package memPkg;

    // Word and line geometry
    localparam int WORD_BITS = 32;
    localparam int LINE_WORDS = 16;
    localparam int LINE_BITS = WORD_BITS * LINE_WORDS;
    localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);

    // Store size, 64 lines of 64 bytes
    localparam int STORE_LINES = 64;
    localparam int LINE_IDX_BITS = $clog2(STORE_LINES);
    localparam int PADDR_BITS = 12;

    // Byte offset width inside one line
    localparam int LINE_OFF_BITS = WORD_SEL_BITS + 2;

    typedef logic [WORD_BITS-1:0] tWord;
    typedef logic [PADDR_BITS-1:0] tPaddr;
    typedef logic [LINE_BITS-1:0] tLine;
    typedef logic [LINE_IDX_BITS-1:0] tLineIdx;
    typedef logic [LINE_WORDS-1:0] tWordMask;
    typedef logic [WORD_SEL_BITS-1:0] tWordSel;

    // Line number, upper address bits
    function automatic tLineIdx lineOf(tPaddr addr);
        return addr[PADDR_BITS-1:LINE_OFF_BITS];
    endfunction

    // Word slot within the line, byte offset dropped
    function automatic tWordSel slotOf(tPaddr addr);
        return addr[LINE_OFF_BITS-1:2];
    endfunction

endpackage

// ==== logic/preloadSequencer.sv ====
`timescale 1ns/1ps

module preloadSequencer (
    input  logic          clk,
    input  logic          rstN,
    input  logic          start,
    input  logic          romMode,
    input  logic          streamValid,
    input  memPkg::tPaddr streamAddr,
    input  memPkg::tWord  streamData,
    input  memPkg::tWord  romData,
    output logic [6:0]    romAddr,
    output logic          wrValid,
    output memPkg::tPaddr wrAddr,
    output memPkg::tWord  wrData,
    output logic          flush,
    output logic          done
);

    typedef enum logic [2:0] {
        stIdle,
        stRomCopy,
        stStream,
        stDrain,
        stDone
    } tSeqState;

    tSeqState state;

    // ROM walk index, doubles as the read address
    logic [6:0] romIdx;
    // Drain timer, flush then line write then done
    logic [1:0] drainCnt;
    // Source of the write data for the current load
    logic romSel;
    // Stream word held for its write cycle
    memPkg::tWord streamDataQ;

    assign romAddr = romIdx;
    assign done = (state == stDone);

    // ROM data lands one cycle after the address, same cycle as wrValid
    assign wrData = romSel ? romData : streamDataQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
            romIdx <= '0;
            drainCnt <= '0;
            romSel <= 1'b0;
            wrValid <= 1'b0;
            flush <= 1'b0;
        end else begin
            // Pulses by default
            wrValid <= 1'b0;
            flush <= 1'b0;
            case (state)
                // Done behaves as idle, a start relaunches
                stIdle, stDone: begin
                    if (start) begin
                        state <= romMode ? stRomCopy : stStream;
                        romSel <= romMode;
                        romIdx <= '0;
                    end
                end
                stRomCopy: begin
                    // Word write for this index issues next cycle
                    wrValid <= 1'b1;
                    romIdx <= romIdx + 7'd1;
                    // Last ROM index
                    if (&romIdx) begin
                        state <= stDrain;
                        drainCnt <= '0;
                    end
                end
                stStream: begin
                    if (streamValid) begin
                        if (streamAddr[0]) begin
                            // Sentinel, nothing written
                            state <= stDrain;
                            drainCnt <= '0;
                        end else begin
                            wrValid <= 1'b1;
                        end
                    end
                end
                stDrain: begin
                    drainCnt <= drainCnt + 2'd1;
                    // Flush once the last word write has gone by
                    flush <= (drainCnt == 2'd0);
                    // Store write lands on this edge
                    if (drainCnt == 2'd2) begin
                        state <= stDone;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Write address and stream payload
    always_ff @(posedge clk) begin
        if (state == stRomCopy) begin
            wrAddr <= memPkg::tPaddr'({romIdx, 2'b00});
        end else if (state == stStream && streamValid) begin
            wrAddr <= streamAddr;
            streamDataQ <= streamData;
        end
    end

    // Source must give word-aligned addresses apart from the sentinel
    streamAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        (state == stStream && streamValid && !streamAddr[0]) |-> !streamAddr[1]
    ) else $error("stream address %h not word aligned", streamAddr);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the boot preload testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bootPreloadTb -f flist.f \
    && ./obj_dir/VbootPreloadTb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation ended without a result line"; exit 1; }
echo "Simulation passed"
exit 0
